// ==== Makefile ====
# Verilator build and run of the amplifier gain controller testbench

TOP := amp_ctrl_tb
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ps --top-module $(TOP) \
		-f flist.f -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== flist.f ====
verilog/amp_pkg.sv
verilog/sck_gen.sv
verilog/spi_master.sv
verilog/amp_ctrl.sv
verification/amp_ctrl_tb.sv

// ==== verification/amp_ctrl_tb.sv ====
`default_nettype none

module amp_ctrl_tb;

	timeunit 1ns;
	timeprecision 1ps;

	////////////////////
	// run settings
	////////////////////

	// short half period keeps the run small
	localparam int div = 3;
	localparam int n_vec = 16;
	// ready low window of one accepted transfer
	localparam int xfer_cycles = 16 * div + 1;
	localparam int timeout_cycles = n_vec * (16 * div + 10) + 200;

	logic           clk50mhz;
	logic           arst_n;
	logic           trig;
	amp_pkg::gain_t gain;
	logic           ready;
	amp_pkg::gain_t rx_word;
	logic           spi_sck;
	logic           spi_mosi;
	logic           amp_cs;
	logic           amp_shdn;
	logic           amp_dout = 1'b0;

	// digit 1 gain_b, digit 2 gain_a, digits 3-4 readback
	logic [15:0] vec_mem [0:n_vec-1];

	// amplifier model shift register and applied gain
	logic [amp_pkg::word_w-1:0] model_q = '0;
	logic [amp_pkg::word_w-1:0] applied_q = '0;

	int sck_rises = 0;
	int cycle_cnt;
	int err_cnt = 0;
	int fail_cnt = 0;

	amp_ctrl #(
		.div(div)
	) u_dut (
		.clk50mhz(clk50mhz),
		.arst_n  (arst_n),
		.trig    (trig),
		.gain    (gain),
		.ready   (ready),
		.rx_word (rx_word),
		.spi_sck (spi_sck),
		.spi_mosi(spi_mosi),
		.amp_cs  (amp_cs),
		.amp_shdn(amp_shdn),
		.amp_dout(amp_dout)
	);

	////////////////////
	// clock and watchdog
	////////////////////

	initial begin
		clk50mhz = 1'b0;
		forever #5 clk50mhz = ~clk50mhz;
	end

	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < timeout_cycles) begin
			@(posedge clk50mhz);
			cycle_cnt++;
		end
		$display("timeout: run still going after %0d cycles", timeout_cycles);
		$display("Test failed");
		$finish;
	end

	////////////////////
	// amplifier model
	////////////////////

	// shift in mosi on sck rise and put the old msb out on dout
	always @(posedge spi_sck) begin
		if (!amp_cs) begin
			amp_dout <= model_q[amp_pkg::word_w-1];
			model_q <= {model_q[amp_pkg::word_w-2:0], spi_mosi};
			sck_rises++;
		end
	end

	// cs release applies the word
	always @(posedge amp_cs) begin
		applied_q <= model_q;
	end

	////////////////////
	// helpers
	////////////////////

	task automatic flag_error(input string msg);
		$display("error %0t: %s", $time, msg);
		err_cnt++;
	endtask

	// behaviour during and right after reset
	task automatic check_reset();
		int err_before;
		err_before = err_cnt;
		repeat (16) begin
			@(negedge clk50mhz);
			if (amp_shdn !== 1'b1) flag_error("amp_shdn not high in reset");
			if (amp_cs !== 1'b1) flag_error("amp_cs not high in reset");
			if (ready !== 1'b1) flag_error("ready not high in reset");
			if (spi_sck !== 1'b0) flag_error("spi_sck not low in reset");
		end
		@(posedge clk50mhz);
		#1;
		arst_n = 1'b1;
		@(negedge clk50mhz);
		if (amp_shdn !== 1'b0) flag_error("amp_shdn still high after reset");
		if (rx_word !== '0) flag_error("rx_word not zero after reset");
		if (err_cnt == err_before) begin
			$display("test reset: ok");
		end else begin
			$display("test reset: fail");
			fail_cnt++;
		end
	endtask

	// one transfer with an optional stray trig half way through
	task automatic run_transfer(
		input  amp_pkg::gain_t word,
		input  bit             inject,
		output int             low_cnt,
		output bit             cs_ok,
		output int             rises
	);
		int rise_start;
		@(posedge clk50mhz);
		#1;
		gain = word;
		trig = 1'b1;
		rise_start = sck_rises;
		low_cnt = 0;
		cs_ok = 1'b1;
		// cs still high in the cycle of the accepted trig
		@(negedge clk50mhz);
		if (amp_cs !== 1'b1) cs_ok = 1'b0;
		@(posedge clk50mhz);
		#1;
		trig = 1'b0;
		@(negedge clk50mhz);
		// count cycles with ready low while cs tracks it
		while (!ready) begin
			low_cnt++;
			if (amp_cs !== 1'b0) cs_ok = 1'b0;
			@(posedge clk50mhz);
			#1;
			if (inject && low_cnt == 4 * div) begin
				trig = 1'b1;
				gain = amp_pkg::gain_t'(~word);
			end else begin
				trig = 1'b0;
				gain = word;
			end
			@(negedge clk50mhz);
		end
		if (amp_cs !== 1'b1) cs_ok = 1'b0;
		rises = sck_rises - rise_start;
	endtask

	////////////////////
	// main sequence
	////////////////////

	initial begin
		int gap;
		int low_cnt;
		int rises;
		int err_before;
		bit cs_ok;
		bit inject;
		amp_pkg::gain_t word;
		amp_pkg::gain_t expect_rx;
		arst_n = 1'b0;
		trig = 1'b0;
		gain = '0;
		void'($urandom(32'h329017d7));
		$readmemh("verification/amp_vectors.txt", vec_mem);
		check_reset();
		for (int i = 0; i < n_vec; i++) begin
			word.gain_b = vec_mem[i][15 -: amp_pkg::gain_w];
			word.gain_a = vec_mem[i][11 -: amp_pkg::gain_w];
			expect_rx = vec_mem[i][7:0];
			// odd vectors get a stray trig mid word
			inject = (i % 2 == 1);
			gap = $urandom % 8;
			repeat (gap) @(posedge clk50mhz);
			err_before = err_cnt;
			run_transfer(word, inject, low_cnt, cs_ok, rises);
			if (low_cnt != xfer_cycles) begin
				flag_error($sformatf("ready low %0d cycles, expected %0d",
					low_cnt, xfer_cycles));
			end
			if (!cs_ok) flag_error("amp_cs not low exactly while ready low");
			if (rises != amp_pkg::word_w) begin
				flag_error($sformatf("%0d sck rises with cs low, expected 8", rises));
			end
			if (applied_q !== word) begin
				flag_error($sformatf("applied %h, expected %h", applied_q, word));
			end
			if (rx_word !== expect_rx) begin
				flag_error($sformatf("rx_word %h, expected %h", rx_word, expect_rx));
			end
			if (err_cnt == err_before) begin
				$display("test %0d word %h%s: ok", i, word, inject ? " stray trig" : "");
			end else begin
				$display("test %0d word %h%s: fail", i, word, inject ? " stray trig" : "");
				fail_cnt++;
			end
		end
		$display("%0d tests, %0d failed, %0d errors", n_vec + 1, fail_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verification/amp_vectors.txt ====
// one transfer per line, 4 hex digits: gain_b, gain_a, expected rx_word (2 digits)
// expected rx_word is the word of the line before, zero for the first
3500
ac35
00ac
ff00
12ff
8412
7e84
5a7e
015a
c301
96c3
e096
2de0
b82d
4fb8
694f

// ==== verilog/amp_ctrl.sv ====
`default_nettype none

module amp_ctrl #(
	// system clocks per sck half period
	// 5 gives a 5 MHz sck from 50 MHz
	parameter int div = 5
) (
	input  logic           clk50mhz,
	input  logic           arst_n,
	// host side
	input  logic           trig,
	input  amp_pkg::gain_t gain,
	output logic           ready,
	output amp_pkg::gain_t rx_word,
	// spi bus
	output logic           spi_sck,
	output logic           spi_mosi,
	// amplifier pins
	output logic           amp_cs,
	output logic           amp_shdn,
	input  logic           amp_dout
);

	////////////////////
	// internal wiring
	////////////////////

	// sck enable from the master
	logic sck_en;

	// one-cycle strobes from the clock generator
	logic sck_rise;
	logic sck_fall;

	////////////////////
	// serial clock
	////////////////////

	// sck goes straight to the pin
	sck_gen #(
		.div(div)
	) u_sck (
		.clk50mhz(clk50mhz),
		.arst_n  (arst_n),
		.en      (sck_en),
		.sck     (spi_sck),
		.rise    (sck_rise),
		.fall    (sck_fall)
	);

	////////////////////
	// shifter
	////////////////////

	// amplifier dout is the miso line
	// chip select is the only slave select on this bus
	spi_master u_spi (
		.clk50mhz(clk50mhz),
		.arst_n  (arst_n),
		.trig    (trig),
		.gain    (gain),
		.ready   (ready),
		.rx_word (rx_word),
		.sck_en  (sck_en),
		.rise    (sck_rise),
		.fall    (sck_fall),
		.mosi    (spi_mosi),
		.cs      (amp_cs),
		.miso    (amp_dout)
	);

	////////////////////
	// shutdown
	////////////////////

	// amplifier held in shutdown for the whole reset
	// released together with the controller
	assign amp_shdn = ~arst_n;

endmodule

`default_nettype wire

// ==== verilog/amp_pkg.sv ====
`default_nettype none

package amp_pkg;

	////////////////////
	// widths
	////////////////////

	// one channel gain code
	parameter int gain_w = 4;

	// full serial word, both channels back to back
	parameter int word_w = 2 * gain_w;

	// bit counter inside the spi master
	parameter int bit_cnt_w = $clog2(word_w);

	////////////////////
	// gain word
	////////////////////

	// channel b sits in the upper nibble
	// the amplifier wants b first on the wire
	// so msb-first shifting of the whole struct gives b then a
	typedef struct packed {
		logic [gain_w-1:0] gain_b;
		logic [gain_w-1:0] gain_a;
	} gain_t;

	////////////////////
	// shifter states
	////////////////////

	// idle waits for trig with cs high
	// shift runs the serial clock for one word
	// finish holds cs low one extra cycle before release
	typedef enum logic [1:0] {
		idle,
		shift,
		finish
	} spi_state_e;

endpackage

`default_nettype wire

// ==== verilog/sck_gen.sv ====
`default_nettype none

module sck_gen #(
	parameter int div = 5
) (
	input  logic clk50mhz,
	input  logic arst_n,
	input  logic en,
	output logic sck,
	output logic rise,
	output logic fall
);

	////////////////////
	// half period counter
	////////////////////

	// div of 2 or more keeps cnt_w at least one bit
	localparam int cnt_w = $clog2(div);

	// terminal count, sck toggles here
	localparam logic [cnt_w-1:0] cnt_last = cnt_w'(div - 1);

	// one before terminal count
	// used to line up the fall strobe with the falling edge
	localparam logic [cnt_w-1:0] cnt_prev = cnt_w'(div - 2);

	logic [cnt_w-1:0] cnt_q;
	logic             sck_q;
	logic             rise_q;
	logic             fall_q;
	logic             at_last;
	logic             at_prev;

	assign at_last = (cnt_q == cnt_last);
	assign at_prev = (cnt_q == cnt_prev);

	// counter and sck level
	// held at zero while disabled so each word
	// begins with a full low half period
	always_ff @(posedge clk50mhz or negedge arst_n) begin
		if (!arst_n) begin
			cnt_q <= '0;
			sck_q <= 1'b0;
		end else if (!en) begin
			cnt_q <= '0;
			sck_q <= 1'b0;
		end else if (at_last) begin
			// end of half period
			cnt_q <= '0;
			sck_q <= ~sck_q;
		end else begin
			cnt_q <= cnt_q + 1'b1;
		end
	end

	////////////////////
	// edge strobes
	////////////////////

	// rise is high in the first cycle with sck high
	// gives the slave a full cycle to drive its data out
	// fall is high in the last cycle with sck high
	// so the master moves mosi on the very edge sck drops
	always_ff @(posedge clk50mhz or negedge arst_n) begin
		if (!arst_n) begin
			rise_q <= 1'b0;
			fall_q <= 1'b0;
		end else begin
			// low half ends, sck about to go high
			rise_q <= en && at_last && !sck_q;
			// high half one cycle from its end
			fall_q <= en && at_prev && sck_q;
		end
	end

	// outputs straight from flops
	assign sck  = sck_q;
	assign rise = rise_q;
	assign fall = fall_q;

endmodule

`default_nettype wire

// ==== verilog/spi_master.sv ====
`default_nettype none

module spi_master (
	input  logic           clk50mhz,
	input  logic           arst_n,
	// host side
	input  logic           trig,
	input  amp_pkg::gain_t gain,
	output logic           ready,
	output amp_pkg::gain_t rx_word,
	// clock generator side
	output logic           sck_en,
	input  logic           rise,
	input  logic           fall,
	// serial pins
	output logic           mosi,
	output logic           cs,
	input  logic           miso
);

	////////////////////
	// constants
	////////////////////

	// index of the last bit in the word
	localparam logic [amp_pkg::bit_cnt_w-1:0] last_bit =
		(amp_pkg::bit_cnt_w)'(amp_pkg::word_w - 1);

	////////////////////
	// state
	////////////////////

	amp_pkg::spi_state_e state_q;
	amp_pkg::spi_state_e state_d;

	// bits already sent in this word
	logic [amp_pkg::bit_cnt_w-1:0] bit_cnt_q;

	// transmit and receive shifters
	logic [amp_pkg::word_w-1:0] tx_q;
	logic [amp_pkg::word_w-1:0] rx_q;

	// returned word, held for the host
	amp_pkg::gain_t rx_word_q;

	// control strobes
	logic load;
	logic sample;
	logic last_fall;
	logic advance;

	// trig only counts while idle
	assign load = (state_q == amp_pkg::idle) && trig;

	// miso is settled one cycle after sck rose
	assign sample = (state_q == amp_pkg::shift) && rise;

	// eighth falling edge closes the word
	assign last_fall = (state_q == amp_pkg::shift) && fall && (bit_cnt_q == last_bit);

	// next bit on every fall except the closing one
	// mosi then keeps bit 0 through finish
	assign advance = (state_q == amp_pkg::shift) && fall && !last_fall;

	////////////////////
	// fsm
	////////////////////

	always_comb begin
		state_d = state_q;
		unique case (state_q)
			amp_pkg::idle: begin
				if (trig) begin
					state_d = amp_pkg::shift;
				end
			end
			amp_pkg::shift: begin
				// sck has just gone low for the last time
				if (last_fall) begin
					state_d = amp_pkg::finish;
				end
			end
			amp_pkg::finish: begin
				// one cycle of cs hold
				state_d = amp_pkg::idle;
			end
			default: begin
				state_d = amp_pkg::idle;
			end
		endcase
	end

	always_ff @(posedge clk50mhz or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= amp_pkg::idle;
		end else begin
			state_q <= state_d;
		end
	end

	////////////////////
	// bit counter
	////////////////////

	// cleared while idle, counts falling edges in shift
	// wraps to zero on the closing edge
	always_ff @(posedge clk50mhz or negedge arst_n) begin
		if (!arst_n) begin
			bit_cnt_q <= '0;
		end else if (state_q == amp_pkg::idle) begin
			bit_cnt_q <= '0;
		end else if ((state_q == amp_pkg::shift) && fall) begin
			bit_cnt_q <= bit_cnt_q + 1'b1;
		end
	end

	////////////////////
	// shifters
	////////////////////

	// tx loads the gain word on the accepted trig
	// msb out first, so b nibble leads
	always_ff @(posedge clk50mhz) begin
		if (load) begin
			tx_q <= gain;
		end else if (advance) begin
			tx_q <= {tx_q[amp_pkg::word_w-2:0], 1'b0};
		end
	end

	// rx fills from the right, first bit ends up as msb
	always_ff @(posedge clk50mhz) begin
		if (sample) begin
			rx_q <= {rx_q[amp_pkg::word_w-2:0], miso};
		end
	end

	// copy to the host on the way back to idle
	// stays put while ready is high
	always_ff @(posedge clk50mhz or negedge arst_n) begin
		if (!arst_n) begin
			rx_word_q <= '0;
		end else if (state_q == amp_pkg::finish) begin
			rx_word_q <= amp_pkg::gain_t'(rx_q);
		end
	end

	////////////////////
	// outputs
	////////////////////

	// ready and cs share one window, both high only in idle
	assign ready = (state_q == amp_pkg::idle);
	assign cs    = (state_q == amp_pkg::idle);

	// serial clock runs only while shifting
	assign sck_en = (state_q == amp_pkg::shift);

	// mosi parked low outside a transfer
	assign mosi = (state_q != amp_pkg::idle) && tx_q[amp_pkg::word_w-1];

	assign rx_word = rx_word_q;

endmodule

`default_nettype wire
